// File: Bender.yml
package:
  name: rab_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rab_pkg.sv
      - rtl/rab_lookup_if.sv
      - rtl/rab_req_arbiter.sv
      - rtl/rab_slice_regs.sv
      - rtl/rab_slice_match.sv
      - rtl/rab_fsm.sv
      - rtl/rab_core.sv
  - target: test
    files:
      - tb/tb_rab_core.sv

// File: rtl/rab_cfg.svh
`ifndef RAB_CFG_SVH
`define RAB_CFG_SVH

// four L1 slices, four config registers each
`define RAB_N_SLICES 4

`define RAB_VIRT_AW  32
`define RAB_PHYS_AW  40

`define RAB_CFG_DW   64
`define RAB_CFG_AW   4

// AXI request fields, 64 bit data bus
`define RAB_LEN_W    8
`define RAB_SIZE_W   3
`define RAB_CTRL_W   6

// bit positions in the flags register
`define RAB_FLAG_EN  0
`define RAB_FLAG_RD  1
`define RAB_FLAG_WR  2
`define RAB_FLAG_COH 3

`endif

// File: rtl/rab_core.sv
`timescale 1ns/1ps

`include "rab_cfg.svh"

module rab_core import rab_pkg::*;
(
  input  logic        Clk_CI,
  input  logic        Rst_RBI,

  // config write port
  input  logic        cfg_we,
  input  cfg_addr_t   cfg_addr,
  input  cfg_word_t   cfg_wdata,

  input  virt_addr_t  p1_addr,
  input  burst_len_t  p1_len,
  input  burst_size_t p1_size,
  input  logic        p1_valid,
  input  logic        p1_write,
  input  ctrl_t       p1_ctrl,
  input  logic        p1_sent,
  output logic        p1_accept,
  output logic        p1_drop,

  input  virt_addr_t  p2_addr,
  input  burst_len_t  p2_len,
  input  burst_size_t p2_size,
  input  logic        p2_valid,
  input  logic        p2_write,
  input  ctrl_t       p2_ctrl,
  input  logic        p2_sent,
  output logic        p2_accept,
  output logic        p2_drop,

  output phys_addr_t  out_addr,        // shared by both channels
  output logic        cache_coherent,

  output logic        int_miss,
  output logic        int_prot,
  output logic        int_multi
);

  cfg_word_t [4*`RAB_N_SLICES-1:0] slice_cfg;

  rab_lookup_if lookup ();

  rab_req_arbiter rab_req_arbiter_i (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .p1_addr  (p1_addr),
    .p1_len   (p1_len),
    .p1_size  (p1_size),
    .p1_valid (p1_valid),
    .p1_write (p1_write),
    .p1_ctrl  (p1_ctrl),
    .p2_addr  (p2_addr),
    .p2_len   (p2_len),
    .p2_size  (p2_size),
    .p2_valid (p2_valid),
    .p2_write (p2_write),
    .p2_ctrl  (p2_ctrl),
    .p1_done  (p1_accept | p1_drop),
    .p2_done  (p2_accept | p2_drop),
    .lookup   (lookup.arbiter)
  );

  rab_slice_regs rab_slice_regs_i (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .slice_cfg (slice_cfg)
  );

  rab_slice_match rab_slice_match_i (
    .slice_cfg (slice_cfg),
    .lookup    (lookup.matcher)
  );

  rab_fsm rab_fsm_i (
    .Clk_CI         (Clk_CI),
    .Rst_RBI        (Rst_RBI),
    .p1_sent        (p1_sent),
    .p2_sent        (p2_sent),
    .lookup         (lookup.fsm),
    .p1_accept      (p1_accept),
    .p1_drop        (p1_drop),
    .p2_accept      (p2_accept),
    .p2_drop        (p2_drop),
    .out_addr       (out_addr),
    .cache_coherent (cache_coherent),
    .int_miss       (int_miss),
    .int_prot       (int_prot),
    .int_multi      (int_multi)
  );

endmodule

// File: rtl/rab_fsm.sv
`timescale 1ns/1ps

module rab_fsm import rab_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,

  input  logic       p1_sent,
  input  logic       p2_sent,

  rab_lookup_if.fsm  lookup,

  output logic       p1_accept,
  output logic       p1_drop,
  output logic       p2_accept,
  output logic       p2_drop,

  output phys_addr_t out_addr,
  output logic       cache_coherent,

  output logic       int_miss,
  output logic       int_prot,
  output logic       int_multi
);

  rab_state_e state;
  logic       sel_q;      // channel being served

  logic       accept;
  logic       miss;
  logic       multi;
  logic       prot;
  phys_addr_t next_addr;
  logic       next_coherent;

  // decision for the request currently on the lookup interface
  always_comb
  begin
    miss          = 1'b0;
    multi         = 1'b0;
    prot          = 1'b0;
    next_addr     = lookup.out_addr;
    next_coherent = lookup.coherent;
    if (lookup.skip)
    begin
      next_addr     = phys_addr_t'(lookup.addr_min);  // pass through untranslated
      next_coherent = 1'b0;
    end
    else if (lookup.no_hit)
      miss = 1'b1;
    else if (lookup.multi_hit)
      multi = 1'b1;
    else if (!lookup.no_prot)
      prot = 1'b1;
  end

  assign accept = !(miss || multi || prot);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state          <= IDLE;
      sel_q          <= 1'b0;
      p1_accept      <= 1'b0;
      p1_drop        <= 1'b0;
      p2_accept      <= 1'b0;
      p2_drop        <= 1'b0;
      int_miss       <= 1'b0;
      int_prot       <= 1'b0;
      int_multi      <= 1'b0;
      out_addr       <= '0;
      cache_coherent <= 1'b0;
    end
    else
    begin
      // pulses last one cycle
      p1_accept <= 1'b0;
      p1_drop   <= 1'b0;
      p2_accept <= 1'b0;
      p2_drop   <= 1'b0;
      int_miss  <= 1'b0;
      int_prot  <= 1'b0;
      int_multi <= 1'b0;
      case (state)
        IDLE:
        begin
          if (lookup.req_valid)
          begin
            sel_q          <= lookup.select;
            p1_accept      <= lookup.select && accept;
            p1_drop        <= lookup.select && !accept;
            p2_accept      <= !lookup.select && accept;
            p2_drop        <= !lookup.select && !accept;
            int_miss       <= miss;
            int_prot       <= prot;
            int_multi      <= multi;
            out_addr       <= next_addr;
            cache_coherent <= next_coherent;
            state          <= RESP;
          end
        end
        RESP:
          state <= (p1_accept || p2_accept) ? WAIT_SENT : IDLE;
        WAIT_SENT:
        begin
          if (sel_q ? p1_sent : p2_sent)  // burst forwarded
            state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

endmodule

// File: rtl/rab_lookup_if.sv
`timescale 1ns/1ps

interface rab_lookup_if import rab_pkg::*; ();

  // selected request
  logic       req_valid;
  logic       select;     // 1: p1, 0: p2
  logic       skip;       // bypass translation
  virt_addr_t addr_min;
  virt_addr_t addr_max;
  logic       write;

  // lookup result, combinational from the current request
  phys_addr_t out_addr;
  logic       coherent;
  logic       no_hit;
  logic       multi_hit;
  logic       no_prot;

  modport arbiter (
    output req_valid, select, skip, addr_min, addr_max, write
  );

  modport matcher (
    input  addr_min, addr_max, write,
    output out_addr, coherent, no_hit, multi_hit, no_prot
  );

  modport fsm (
    input req_valid, select, skip, addr_min, addr_max, write,
    input out_addr, coherent, no_hit, multi_hit, no_prot
  );

endinterface

// File: rtl/rab_pkg.sv
`include "rab_cfg.svh"

package rab_pkg;

  typedef logic [`RAB_VIRT_AW-1:0]  virt_addr_t;
  typedef logic [`RAB_PHYS_AW-1:0]  phys_addr_t;

  typedef logic [`RAB_CFG_DW-1:0]   cfg_word_t;
  typedef logic [`RAB_CFG_AW-1:0]   cfg_addr_t;

  typedef logic [`RAB_LEN_W-1:0]    burst_len_t;
  typedef logic [`RAB_SIZE_W-1:0]   burst_size_t;
  typedef logic [`RAB_CTRL_W-1:0]   ctrl_t;    // AXI user bits

  typedef logic [`RAB_N_SLICES-1:0] slice_vec_t;

  // IDLE evaluates, RESP pulses accept or drop, WAIT_SENT holds until
  // the burst has been forwarded
  typedef enum logic [1:0] {
    IDLE,
    RESP,
    WAIT_SENT
  } rab_state_e;

endpackage

// File: rtl/rab_req_arbiter.sv
`timescale 1ns/1ps

`include "rab_cfg.svh"

module rab_req_arbiter import rab_pkg::*;
(
  input  logic        Clk_CI,
  input  logic        Rst_RBI,

  input  virt_addr_t  p1_addr,
  input  burst_len_t  p1_len,
  input  burst_size_t p1_size,
  input  logic        p1_valid,
  input  logic        p1_write,
  input  ctrl_t       p1_ctrl,

  input  virt_addr_t  p2_addr,
  input  burst_len_t  p2_len,
  input  burst_size_t p2_size,
  input  logic        p2_valid,
  input  logic        p2_write,
  input  ctrl_t       p2_ctrl,

  input  logic        p1_done,   // accept or drop of p1
  input  logic        p2_done,

  rab_lookup_if.arbiter lookup
);

  logic       curr_priority;   // 1 after p1 was served last
  logic       select;
  virt_addr_t p1_max_addr;
  virt_addr_t p2_max_addr;

  // last byte of the burst, start aligned down to the beat size first
  function automatic virt_addr_t burst_end(virt_addr_t addr, burst_len_t len,
                                           burst_size_t size);
    logic [`RAB_SIZE_W-1:0] mask;
    virt_addr_t             align_addr;
    virt_addr_t             burst_bytes;
    case (size)
      3'b001:  mask = 3'b110;
      3'b010:  mask = 3'b100;
      3'b011:  mask = 3'b000;
      default: mask = 3'b111;
    endcase
    align_addr  = {addr[`RAB_VIRT_AW-1:`RAB_SIZE_W], addr[`RAB_SIZE_W-1:0] & mask};
    burst_bytes = (virt_addr_t'(len) + 1) << size;
    return align_addr + burst_bytes - 1;
  endfunction

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      curr_priority <= 1'b0;
    else if (p1_done)
      curr_priority <= 1'b1;
    else if (p2_done)
      curr_priority <= 1'b0;
  end

  // sticky priority, p2 wins unless p1 was served last
  assign select = (curr_priority & p1_valid) | ~p2_valid;

  assign p1_max_addr = burst_end(p1_addr, p1_len, p1_size);
  assign p2_max_addr = burst_end(p2_addr, p2_len, p2_size);

  assign lookup.select    = select;
  assign lookup.req_valid = select ? p1_valid : p2_valid;
  assign lookup.addr_min  = select ? p1_addr : p2_addr;
  assign lookup.addr_max  = select ? p1_max_addr : p2_max_addr;
  assign lookup.write     = select ? p1_write : p2_write;
  assign lookup.skip      = select ? (p1_ctrl == '1) : (p2_ctrl == '1);  // ctrl all ones

endmodule

// File: rtl/rab_slice_match.sv
`timescale 1ns/1ps

`include "rab_cfg.svh"

module rab_slice_match import rab_pkg::*;
(
  input  cfg_word_t [4*`RAB_N_SLICES-1:0] slice_cfg,

  rab_lookup_if.matcher lookup
);

  virt_addr_t  addr_start [`RAB_N_SLICES];
  virt_addr_t  addr_end   [`RAB_N_SLICES];
  phys_addr_t  addr_offset[`RAB_N_SLICES];
  cfg_word_t   flags      [`RAB_N_SLICES];

  slice_vec_t  hit;
  slice_vec_t  prot;
  int unsigned n_hits;

  // unpack the register file
  always_comb
  begin
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      addr_start[s]  = slice_cfg[4*s][`RAB_VIRT_AW-1:0];
      addr_end[s]    = slice_cfg[4*s+1][`RAB_VIRT_AW-1:0];
      addr_offset[s] = slice_cfg[4*s+2][`RAB_PHYS_AW-1:0];
      flags[s]       = slice_cfg[4*s+3];
    end
  end

  // whole burst has to fit in the slice
  always_comb
  begin
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      hit[s]  = flags[s][`RAB_FLAG_EN]
                && (addr_start[s] <= lookup.addr_min)
                && (lookup.addr_max <= addr_end[s]);
      prot[s] = hit[s] && (lookup.write ? !flags[s][`RAB_FLAG_WR]
                                        : !flags[s][`RAB_FLAG_RD]);
    end
  end

  always_comb
  begin
    n_hits = 0;
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      n_hits += hit[s];
    end
  end

  // translation of the hitting slice, only meaningful with a single hit
  always_comb
  begin
    lookup.out_addr = '0;
    lookup.coherent = 1'b0;
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      if (hit[s])
      begin
        lookup.out_addr = phys_addr_t'(lookup.addr_min - addr_start[s]) + addr_offset[s];
        lookup.coherent = flags[s][`RAB_FLAG_COH];
      end
    end
  end

  assign lookup.no_hit    = ~|hit;
  assign lookup.no_prot   = ~|prot;
  assign lookup.multi_hit = (n_hits > 1);

endmodule

// File: rtl/rab_slice_regs.sv
`timescale 1ns/1ps

`include "rab_cfg.svh"

module rab_slice_regs import rab_pkg::*;
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,

  input  logic      cfg_we,
  input  cfg_addr_t cfg_addr,
  input  cfg_word_t cfg_wdata,

  // index 4s+f: start, end, offset, flags of slice s
  output cfg_word_t [4*`RAB_N_SLICES-1:0] slice_cfg
);

  logic [4*`RAB_N_SLICES-1:0] reg_we;

  // one-hot write enable per register
  always_comb
  begin
    for (int i = 0; i < 4*`RAB_N_SLICES; i++)
    begin
      reg_we[i] = cfg_we && (cfg_addr == cfg_addr_t'(i));
    end
  end

  // all zero after reset, so every slice starts disabled
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      slice_cfg <= '0;
    end
    else
    begin
      for (int i = 0; i < 4*`RAB_N_SLICES; i++)
      begin
        if (reg_we[i])
          slice_cfg[i] <= cfg_wdata;
      end
    end
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/rab_pkg.sv
rtl/rab_lookup_if.sv
rtl/rab_req_arbiter.sv
rtl/rab_slice_regs.sv
rtl/rab_slice_match.sv
rtl/rab_fsm.sv
rtl/rab_core.sv
tb/tb_rab_core.sv

// File: tb/rab_stimulus.txt
# C: register index (4*slice+field, hex) and data; R: name, channel p1/p2/both, then per request
# addr len size write ctrl outcome exp_out_addr exp_coherent (both lists p1 then p2)
R reset_both both 00001000 00 3 0 00 miss 0000000000 0 00002000 00 2 1 00 miss 0000000000 0
C 0 0000000000001000
C 1 0000000000001fff
C 2 0000001000000000
C 3 000000000000000f
C 4 0000000000004000
C 5 0000000000004fff
C 6 0000000200000000
C 7 0000000000000003
C 8 0000000000008000
C 9 0000000000008fff
C a 0000000000800000
C b 0000000000000007
C c 0000000000008800
C d 0000000000008fff
C e 0000000000001000
C f 0000000000000007
R rd_s0 p2 00001100 03 3 0 00 accept 1000000100 1
R wr_s0 p1 00001ff8 00 3 1 00 accept 1000000ff8 1
R rd_s1 p1 00004020 01 2 0 00 accept 0200000020 0
R rd_s2 p2 00008100 00 2 0 00 accept 0000800100 0
R end_miss p2 00001ff8 01 3 0 00 miss 0000000000 0
R unal_size2 p1 00001ffe 00 2 0 00 accept 1000000ffe 1
R unal_size3 p2 00001ffd 00 3 1 00 accept 1000000ffd 1
R unal_len1 p1 00001ff5 01 3 0 00 accept 1000000ff5 1
R wr_prot p1 00004100 00 2 1 00 prot 0000000000 0
R overlap p2 00008800 00 2 0 00 multi 0000000000 0
R bypass p2 00300004 00 2 1 3f accept 0000300004 0
R both_acc both 00001040 00 3 0 00 accept 1000000040 1 00004080 00 2 0 00 accept 0200000080 0
R both_mix both 00004100 00 2 1 00 prot 0000000000 0 00001200 00 3 0 00 accept 1000000200 1
R both_last both 00008010 00 2 1 00 accept 0000800010 0 00009000 00 2 0 00 miss 0000000000 0

// File: tb/tb_rab_core.sv
`timescale 1ns/1ps

module tb_rab_core import rab_pkg::*;
();

  logic        Clk_CI;
  logic        Rst_RBI;
  logic        cfg_we;
  cfg_addr_t   cfg_addr;
  cfg_word_t   cfg_wdata;
  virt_addr_t  p1_addr, p2_addr;
  burst_len_t  p1_len, p2_len;
  burst_size_t p1_size, p2_size;
  logic        p1_valid, p2_valid, p1_write, p2_write, p1_sent, p2_sent;
  ctrl_t       p1_ctrl, p2_ctrl;
  logic        p1_accept, p1_drop, p2_accept, p2_drop;
  phys_addr_t  out_addr;
  logic        cache_coherent, int_miss, int_prot, int_multi;

  // expected results, indexed by channel number
  string       exp_kind [1:2];
  phys_addr_t  exp_addr [1:2];
  logic        exp_coh  [1:2];
  string       test_name;
  logic        last_p1;    // model of the sticky priority
  int          n_lines;

  rab_core rab_core_i (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #10 Clk_CI = ~Clk_CI;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "test stopped");
  endtask

  task automatic check_phys(input string name, input phys_addr_t expected, input phys_addr_t actual);
    if (expected !== actual)
      stop_with_failure($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (expected !== actual)
      stop_with_failure($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
  endtask

  task automatic check_outcome(input string name, input logic expected, input logic actual);
    if (expected !== actual)
      stop_with_failure($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
  endtask

  function automatic logic other_done(input int ch);
    return (ch == 1) ? (p2_accept | p2_drop) : (p1_accept | p1_drop);
  endfunction

  // read one request and put it on its channel
  task automatic read_request(input int fd, input int ch);
    virt_addr_t  a;
    burst_len_t  len;
    burst_size_t size;
    logic        wr;
    ctrl_t       ctrl;
    int          code;
    code = $fscanf(fd, "%h %h %h %h %h %s %h %h", a, len, size, wr, ctrl, exp_kind[ch],
                   exp_addr[ch], exp_coh[ch]);
    if (code != 8)
      stop_with_failure("stimulus file has a malformed request line");
    if (ch == 1)
    begin
      p1_addr  = a;
      p1_len   = len;
      p1_size  = size;
      p1_write = wr;
      p1_ctrl  = ctrl;
    end
    else
    begin
      p2_addr  = a;
      p2_len   = len;
      p2_size  = size;
      p2_write = wr;
      p2_ctrl  = ctrl;
    end
  endtask

  // wait for the decision on one channel, check it, then forward the burst
  task automatic serve(input int ch);
    logic acc, drp;
    int   delay;
    string name;
    name = $sformatf("%s.p%0d", test_name, ch);
    acc  = 1'b0;
    drp  = 1'b0;
    while (!(acc || drp))
    begin
      @(negedge Clk_CI);
      if (other_done(ch))
        stop_with_failure({name, ": the other channel was answered out of order"});
      acc = (ch == 1) ? p1_accept : p2_accept;
      drp = (ch == 1) ? p1_drop : p2_drop;
    end
    check_outcome({name, ".accept"}, exp_kind[ch] == "accept", acc);
    check_outcome({name, ".drop"}, exp_kind[ch] != "accept", drp);
    check_flag({name, ".int_miss"}, exp_kind[ch] == "miss", int_miss);
    check_flag({name, ".int_prot"}, exp_kind[ch] == "prot", int_prot);
    check_flag({name, ".int_multi"}, exp_kind[ch] == "multi", int_multi);
    if (ch == 1) p1_valid = 1'b0;
    else         p2_valid = 1'b0;
    if (acc)
    begin
      check_phys({name, ".out_addr"}, exp_addr[ch], out_addr);
      check_flag({name, ".coherent"}, exp_coh[ch], cache_coherent);
      delay = $urandom_range(5, 0);
      repeat (delay + 1)   // FSM reaches WAIT_SENT one edge after accept
      begin
        @(negedge Clk_CI);
        if (other_done(ch))
          stop_with_failure({name, ": a second decision came before sent"});
      end
      if (ch == 1) p1_sent = 1'b1;
      else         p2_sent = 1'b1;
      @(negedge Clk_CI);
      p1_sent = 1'b0;
      p2_sent = 1'b0;
    end
    last_p1 = (ch == 1);
  endtask

  // ends the run if the stimulus does not complete in time
  initial
  begin
    wait (n_lines > 0);
    repeat (16 + n_lines * 40) @(posedge Clk_CI);
    stop_with_failure("timeout: the stimulus did not finish in time");
  end

  initial
  begin
    int        fd, code, first;
    cfg_addr_t idx;
    string     tok, chan, line;
    cfg_word_t data;
    void'($urandom(32'h950d_fc4d));
    Rst_RBI   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    p1_addr   = '0;
    p1_len    = '0;
    p1_size   = '0;
    p1_valid  = 1'b0;
    p1_write  = 1'b0;
    p1_ctrl   = '0;
    p1_sent   = 1'b0;
    p2_addr   = '0;
    p2_len    = '0;
    p2_size   = '0;
    p2_valid  = 1'b0;
    p2_write  = 1'b0;
    p2_ctrl   = '0;
    p2_sent   = 1'b0;
    last_p1   = 1'b0;
    n_lines   = 0;
    fd = $fopen("tb/rab_stimulus.txt", "r");
    if (fd == 0)
      stop_with_failure("cannot open tb/rab_stimulus.txt");
    while ($fgets(line, fd))
      n_lines++;
    $fclose(fd);
    fd = $fopen("tb/rab_stimulus.txt", "r");
    repeat (16) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    check_phys("reset.out_addr", '0, out_addr);
    check_flag("reset.accept", 1'b0, p1_accept | p2_accept);
    check_flag("reset.drop", 1'b0, p1_drop | p2_drop);
    check_flag("reset.int", 1'b0, int_miss | int_prot | int_multi);
    while ($fscanf(fd, "%s", tok) == 1)
    begin
      if (tok[0] == "#")
        code = $fgets(line, fd);   // rest of a comment line
      else if (tok == "C")
      begin
        code = $fscanf(fd, "%h %h", idx, data);
        if (code != 2)
          stop_with_failure("stimulus file has a malformed config line");
        cfg_we    = 1'b1;
        cfg_addr  = idx;
        cfg_wdata = data;
        @(negedge Clk_CI);
        cfg_we = 1'b0;
      end
      else if (tok == "R")
      begin
        code = $fscanf(fd, "%s %s", test_name, chan);
        if (code != 2)
          stop_with_failure("stimulus file has a malformed request line");
        if (chan == "both")
        begin
          read_request(fd, 1);
          read_request(fd, 2);
          p1_valid = 1'b1;
          p2_valid = 1'b1;
          first = last_p1 ? 1 : 2;
          serve(first);
          serve(3 - first);
        end
        else
        begin
          first = (chan == "p1") ? 1 : 2;
          read_request(fd, first);
          if (first == 1) p1_valid = 1'b1;
          else            p2_valid = 1'b1;
          serve(first);
        end
      end
      else
        stop_with_failure({"unknown line kind in stimulus file: ", tok});
    end
    $fclose(fd);
    $display("Result: PASSED");
    $finish;
  end

endmodule
